/* logic/pcie_prof_pkg.sv */
`default_nettype none

package pcie_prof_pkg;

    // host physical address, also used for the immediate data word
    typedef logic [63:0] host_addr_t;

    // descriptor length in dwords
    typedef logic [17:0] dword_cnt_t;

    typedef logic [7:0] desc_id_t;

    // one payload buffer line
    typedef logic [511:0] line_t;

    // statistic counters and request counts
    typedef logic [31:0] count_t;

    // card-side window that holds the payload buffer
    localparam logic [31:0] EP_BASE_ADDR = 32'h0004_0000;

    // payload line offset inside the window
    localparam logic [31:0] BRAM_OFFSET = 32'd0;

    localparam desc_id_t DONE_ID = 8'hFE;
    localparam desc_id_t DATA_ID = 8'h00;

    // successive data descriptors land one page apart in the host ring
    localparam host_addr_t PAGE_BYTES = 64'd4096;

    // start of the host ring is kept free for the done word
    localparam host_addr_t HOST_HDR_BYTES = 64'd64;

    // consecutive ready cycles before the data mover holds a slot
    localparam int READY_HOLD = 3;

endpackage

`default_nettype wire

/* logic/desc_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface desc_if;
    import pcie_prof_pkg::*;

    logic       valid;
    logic       ready;
    host_addr_t dst_addr;
    // source address, or the data word itself for immediate descriptors
    host_addr_t src_data;
    dword_cnt_t nb_dwords;
    logic       immediate;
    desc_id_t   desc_id;

    modport src (output valid, dst_addr, src_data, nb_dwords, immediate, desc_id,
                 input  ready);

    modport dst (input  valid, dst_addr, src_data, nb_dwords, immediate, desc_id,
                 output ready);

    modport mon (input valid, ready, dst_addr, src_data, nb_dwords, immediate, desc_id);

endinterface

`default_nettype wire

/* logic/data_desc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module data_desc_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      write_pointer,
    input  pcie_prof_pkg::count_t     target_nb_requests,
    input  pcie_prof_pkg::count_t     req_size,
    input  logic [30:0]               rb_size,
    input  pcie_prof_pkg::host_addr_t kmem_addr,
    output pcie_prof_pkg::count_t     nb_requests,
    output pcie_prof_pkg::host_addr_t page_offset,
    output logic                      run_busy,
    desc_if.src                       data_ch,
    desc_if.mon                       done_ch
);
    import pcie_prof_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_offer,
        st_wait_done
    } state_t;

    state_t     state;
    host_addr_t req_bytes;
    host_addr_t ring_bytes;
    host_addr_t next_offset;
    logic       data_acc;
    logic       done_acc;

    assign data_acc = data_ch.valid && data_ch.ready;
    assign done_acc = done_ch.valid && done_ch.ready;

    // ring size comes in 64-byte lines, request size in dwords
    assign req_bytes  = host_addr_t'({req_size, 2'b00});
    assign ring_bytes = host_addr_t'({rb_size, 6'd0});

    // back to the ring start when the next transfer would run past the end
    assign next_offset = (page_offset + PAGE_BYTES + req_bytes > ring_bytes) ?
                         '0 : page_offset + PAGE_BYTES;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            nb_requests <= '0;
            page_offset <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        nb_requests <= '0;
                        page_offset <= '0;
                        if (target_nb_requests != '0) begin
                            state <= st_offer;
                        end
                    end
                end
                st_offer: begin
                    if (data_acc) begin
                        nb_requests <= nb_requests + 1'b1;
                        page_offset <= next_offset;
                        if (write_pointer) begin
                            state <= st_wait_done;
                        end else if (nb_requests + 1'b1 == target_nb_requests) begin
                            state <= st_idle;
                        end
                    end
                end
                st_wait_done: begin
                    // count is already advanced here
                    if (done_acc) begin
                        if (nb_requests == target_nb_requests) begin
                            state <= st_idle;
                        end else begin
                            state <= st_offer;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign run_busy = (state != st_idle);

    assign data_ch.valid     = (state == st_offer);
    assign data_ch.dst_addr  = kmem_addr + HOST_HDR_BYTES + page_offset;
    assign data_ch.src_data  = {32'h0, EP_BASE_ADDR + {BRAM_OFFSET[25:0], 6'd0}};
    assign data_ch.nb_dwords = dword_cnt_t'(req_size);
    assign data_ch.immediate = 1'b0;
    assign data_ch.desc_id   = DATA_ID;

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        data_ch.valid && !data_ch.ready |=> data_ch.valid && $stable(data_ch.dst_addr)
            && $stable(data_ch.nb_dwords))
        else $error("data_desc_gen: data descriptor withdrawn or changed before acceptance");

endmodule

`default_nettype wire

/* logic/done_desc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module done_desc_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write_pointer,
    input  pcie_prof_pkg::host_addr_t kmem_addr,
    input  pcie_prof_pkg::count_t     nb_requests,
    input  pcie_prof_pkg::host_addr_t page_offset,
    desc_if.mon                       data_ch,
    desc_if.src                       done_ch
);
    import pcie_prof_pkg::*;

    logic armed;
    logic arm;

    assign arm = write_pointer && data_ch.valid && data_ch.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (arm) begin
            armed <= 1'b1;
        end else if (done_ch.valid && done_ch.ready) begin
            armed <= 1'b0;
        end
    end

    // offset and count were advanced by the data acceptance that armed us
    assign done_ch.valid     = armed;
    assign done_ch.dst_addr  = kmem_addr + page_offset;
    assign done_ch.src_data  = {32'h0, nb_requests};
    assign done_ch.nb_dwords = dword_cnt_t'(1);
    assign done_ch.immediate = 1'b1;
    assign done_ch.desc_id   = DONE_ID;

    a_single_arm: assert property (@(posedge clk) disable iff (rst)
        arm |-> !armed)
        else $error("done_desc_gen: data accepted while a done descriptor is pending");

endmodule

`default_nettype wire

/* logic/desc_issuer.sv */
`timescale 1ns/1ns
`default_nettype none

module desc_issuer (
    input  logic                      clk,
    input  logic                      rst,
    desc_if.dst                       data_ch,
    desc_if.dst                       done_ch,
    output logic                      wrdm_desc_valid,
    input  logic                      wrdm_desc_ready,
    output pcie_prof_pkg::host_addr_t wrdm_desc_dst_addr,
    output pcie_prof_pkg::host_addr_t wrdm_desc_src_data,
    output pcie_prof_pkg::dword_cnt_t wrdm_desc_nb_dwords,
    output logic                      wrdm_desc_immediate,
    output pcie_prof_pkg::desc_id_t   wrdm_desc_id,
    input  logic                      run_busy_in,
    output pcie_prof_pkg::count_t     dma_queue_full_cnt,
    output pcie_prof_pkg::count_t     transmit_cycles
);
    import pcie_prof_pkg::*;

    // ready seen in the previous READY_HOLD-1 cycles
    logic [READY_HOLD-2:0] ready_hist;
    logic                  hold_ok;
    logic                  held;
    logic                  sel_done;
    logic                  offer_q;
    logic                  pending;
    logic                  capture;
    logic                  run_busy_q;

    assign hold_ok = wrdm_desc_ready && (&ready_hist);
    assign capture = !held && (done_ch.valid || data_ch.valid);

    // ready may drop in the same cycle as the offer, so gate it here
    assign wrdm_desc_valid = offer_q && wrdm_desc_ready;

    // a channel only sees ready when the data mover takes its descriptor
    assign data_ch.ready = wrdm_desc_valid && !sel_done;
    assign done_ch.ready = wrdm_desc_valid && sel_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_hist <= '0;
        end else begin
            ready_hist <= {ready_hist[READY_HOLD-3:0], wrdm_desc_ready};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held     <= 1'b0;
            sel_done <= 1'b0;
            offer_q  <= 1'b0;
            pending  <= 1'b0;
        end else begin
            offer_q <= 1'b0;
            if (held) begin
                if (wrdm_desc_valid) begin
                    held    <= 1'b0;
                    pending <= 1'b0;
                end else if (offer_q) begin
                    // missed the slot, keep the descriptor for a retry
                    pending <= 1'b1;
                end else if (pending && hold_ok) begin
                    offer_q <= 1'b1;
                    pending <= 1'b0;
                end
            end else if (capture) begin
                held     <= 1'b1;
                sel_done <= done_ch.valid;
                if (hold_ok) begin
                    offer_q <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // done has priority so each data is followed by its done
    always_ff @(posedge clk) begin
        if (capture) begin
            if (done_ch.valid) begin
                wrdm_desc_dst_addr  <= done_ch.dst_addr;
                wrdm_desc_src_data  <= done_ch.src_data;
                wrdm_desc_nb_dwords <= done_ch.nb_dwords;
                wrdm_desc_immediate <= done_ch.immediate;
                wrdm_desc_id        <= done_ch.desc_id;
            end else begin
                wrdm_desc_dst_addr  <= data_ch.dst_addr;
                wrdm_desc_src_data  <= data_ch.src_data;
                wrdm_desc_nb_dwords <= data_ch.nb_dwords;
                wrdm_desc_immediate <= data_ch.immediate;
                wrdm_desc_id        <= data_ch.desc_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_queue_full_cnt <= '0;
            transmit_cycles    <= '0;
            run_busy_q         <= 1'b0;
        end else begin
            run_busy_q <= run_busy_in;
            if (held && !wrdm_desc_valid) begin
                dma_queue_full_cnt <= dma_queue_full_cnt + 1'b1;
            end
            // a new run starts counting from its first busy cycle
            if (run_busy_in && !run_busy_q) begin
                transmit_cycles <= count_t'(1);
            end else if (run_busy_in) begin
                transmit_cycles <= transmit_cycles + 1'b1;
            end
        end
    end

    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        wrdm_desc_valid |-> $past(wrdm_desc_ready, 1) && $past(wrdm_desc_ready, 2))
        else $error("desc_issuer: descriptor offered without three ready cycles");

endmodule

`default_nettype wire

/* logic/payload_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module payload_buffer #(
    parameter int PDU_AWIDTH = 6,
    parameter int PDU_DEPTH  = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  use_bram,
    input  logic                  frb_read,
    input  logic [PDU_AWIDTH-1:0] frb_address,
    output logic                  frb_readvalid,
    output pcie_prof_pkg::line_t  frb_readdata
);
    import pcie_prof_pkg::*;

    localparam line_t FIXED_PATTERN = {8{64'hdead0000beef0000}};

    line_t                 mem [PDU_DEPTH];
    line_t                 mem_q;
    logic [PDU_AWIDTH-1:0] fill_addr;
    logic [PDU_AWIDTH-1:0] rd_addr_q;
    logic                  filling;
    logic                  read_q;

    // one line per cycle after reset, tagged with its index
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_addr <= '0;
            filling   <= 1'b1;
        end else if (filling) begin
            fill_addr <= fill_addr + 1'b1;
            if (fill_addr == PDU_AWIDTH'(PDU_DEPTH - 1)) begin
                filling <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (filling) begin
            mem[fill_addr] <= {16{16'hbabe, 16'(fill_addr)}};
        end
    end

    // address register then registered memory output
    always_ff @(posedge clk) begin
        if (frb_read) begin
            rd_addr_q <= frb_address;
        end
        if (read_q) begin
            mem_q <= mem[rd_addr_q];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_q        <= 1'b0;
            frb_readvalid <= 1'b0;
        end else begin
            read_q        <= frb_read;
            frb_readvalid <= use_bram ? read_q : frb_read;
        end
    end

    assign frb_readdata = use_bram ? mem_q : FIXED_PATTERN;

endmodule

`default_nettype wire

/* logic/pcie_tx_profiler.sv */
`timescale 1ns/1ns
`default_nettype none

module pcie_tx_profiler #(
    parameter int PDU_AWIDTH = 6,
    parameter int PDU_DEPTH  = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      write_pointer,
    input  logic                      use_bram,
    input  pcie_prof_pkg::count_t     target_nb_requests,
    input  pcie_prof_pkg::count_t     req_size,
    input  logic [30:0]               rb_size,
    input  pcie_prof_pkg::host_addr_t kmem_addr,

    // write data mover descriptor port
    output logic                      wrdm_desc_valid,
    input  logic                      wrdm_desc_ready,
    output pcie_prof_pkg::host_addr_t wrdm_desc_dst_addr,
    output pcie_prof_pkg::host_addr_t wrdm_desc_src_data,
    output pcie_prof_pkg::dword_cnt_t wrdm_desc_nb_dwords,
    output logic                      wrdm_desc_immediate,
    output pcie_prof_pkg::desc_id_t   wrdm_desc_id,

    // data mover reads of the payload
    input  logic                      frb_read,
    input  logic [PDU_AWIDTH-1:0]     frb_address,
    output logic                      frb_readvalid,
    output pcie_prof_pkg::line_t      frb_readdata,

    output logic                      run_busy,
    output pcie_prof_pkg::count_t     dma_queue_full_cnt,
    output pcie_prof_pkg::count_t     transmit_cycles
);
    import pcie_prof_pkg::*;

    count_t     nb_requests;
    host_addr_t page_offset;

    desc_if data_ch ();
    desc_if done_ch ();

    data_desc_gen data_desc_gen_i (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .write_pointer      (write_pointer),
        .target_nb_requests (target_nb_requests),
        .req_size           (req_size),
        .rb_size            (rb_size),
        .kmem_addr          (kmem_addr),
        .nb_requests        (nb_requests),
        .page_offset        (page_offset),
        .run_busy           (run_busy),
        .data_ch            (data_ch.src),
        .done_ch            (done_ch.mon)
    );

    done_desc_gen done_desc_gen_i (
        .clk           (clk),
        .rst           (rst),
        .write_pointer (write_pointer),
        .kmem_addr     (kmem_addr),
        .nb_requests   (nb_requests),
        .page_offset   (page_offset),
        .data_ch       (data_ch.mon),
        .done_ch       (done_ch.src)
    );

    desc_issuer desc_issuer_i (
        .clk                 (clk),
        .rst                 (rst),
        .data_ch             (data_ch.dst),
        .done_ch             (done_ch.dst),
        .wrdm_desc_valid     (wrdm_desc_valid),
        .wrdm_desc_ready     (wrdm_desc_ready),
        .wrdm_desc_dst_addr  (wrdm_desc_dst_addr),
        .wrdm_desc_src_data  (wrdm_desc_src_data),
        .wrdm_desc_nb_dwords (wrdm_desc_nb_dwords),
        .wrdm_desc_immediate (wrdm_desc_immediate),
        .wrdm_desc_id        (wrdm_desc_id),
        .run_busy_in         (run_busy),
        .dma_queue_full_cnt  (dma_queue_full_cnt),
        .transmit_cycles     (transmit_cycles)
    );

    payload_buffer #(
        .PDU_AWIDTH (PDU_AWIDTH),
        .PDU_DEPTH  (PDU_DEPTH)
    ) payload_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .use_bram      (use_bram),
        .frb_read      (frb_read),
        .frb_address   (frb_address),
        .frb_readvalid (frb_readvalid),
        .frb_readdata  (frb_readdata)
    );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release reset just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_pcie_tx_profiler.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_tx_profiler;
    import pcie_prof_pkg::*;

    typedef enum {ready_low, ready_high, ready_random} ready_mode_t;

    logic        clk;
    logic        rst;
    logic        start;
    logic        write_pointer;
    logic        use_bram;
    count_t      target_nb_requests;
    count_t      req_size;
    logic [30:0] rb_size;
    host_addr_t  kmem_addr;
    logic        wrdm_desc_valid;
    logic        wrdm_desc_ready;
    host_addr_t  wrdm_desc_dst_addr;
    host_addr_t  wrdm_desc_src_data;
    dword_cnt_t  wrdm_desc_nb_dwords;
    logic        wrdm_desc_immediate;
    desc_id_t    wrdm_desc_id;
    logic        frb_read;
    logic [5:0]  frb_address;
    logic        frb_readvalid;
    line_t       frb_readdata;
    logic        run_busy;
    count_t      dma_queue_full_cnt;
    count_t      transmit_cycles;

    string       test_name;
    int          errors;
    int          timeouts;
    ready_mode_t ready_mode;
    ready_mode_t mode_now;
    integer      seed = 15;
    line_t       exp_line;
    logic        accepted;

    // reference model of the descriptor stream
    host_addr_t  m_offset;
    count_t      m_count;
    logic        m_done_next;
    int          m_wraps;
    int          acc_data;
    int          acc_done;
    int          busy_cnt;
    host_addr_t  first_dst;
    host_addr_t  exp_dst;
    host_addr_t  exp_src;
    logic [26:0] exp_attr;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    pcie_tx_profiler pcie_tx_profiler_i (
        .clk                 (clk),
        .rst                 (rst),
        .start               (start),
        .write_pointer       (write_pointer),
        .use_bram            (use_bram),
        .target_nb_requests  (target_nb_requests),
        .req_size            (req_size),
        .rb_size             (rb_size),
        .kmem_addr           (kmem_addr),
        .wrdm_desc_valid     (wrdm_desc_valid),
        .wrdm_desc_ready     (wrdm_desc_ready),
        .wrdm_desc_dst_addr  (wrdm_desc_dst_addr),
        .wrdm_desc_src_data  (wrdm_desc_src_data),
        .wrdm_desc_nb_dwords (wrdm_desc_nb_dwords),
        .wrdm_desc_immediate (wrdm_desc_immediate),
        .wrdm_desc_id        (wrdm_desc_id),
        .frb_read            (frb_read),
        .frb_address         (frb_address),
        .frb_readvalid       (frb_readvalid),
        .frb_readdata        (frb_readdata),
        .run_busy            (run_busy),
        .dma_queue_full_cnt  (dma_queue_full_cnt),
        .transmit_cycles     (transmit_cycles)
    );

    assign accepted = wrdm_desc_valid && wrdm_desc_ready;

    // next page, or back to the ring start if the transfer would run past the end
    function automatic host_addr_t next_page(input host_addr_t offset);
        host_addr_t ring_end;
        host_addr_t req_end;
        ring_end = host_addr_t'(rb_size) * 64;
        req_end  = offset + 4096 + host_addr_t'(req_size) * 4;
        if (req_end > ring_end) begin
            return '0;
        end
        return offset + 4096;
    endfunction

    function automatic line_t babe_line(input logic [5:0] idx);
        line_t l;
        int    k;
        for (k = 0; k < 16; k++) begin
            l[k*32 +: 32] = {16'hbabe, 10'd0, idx};
        end
        return l;
    endfunction

    function automatic line_t fixed_line();
        line_t l;
        int    k;
        for (k = 0; k < 8; k++) begin
            l[k*64 +: 64] = 64'hdead0000beef0000;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            m_offset    <= '0;
            m_count     <= '0;
            m_done_next <= 1'b0;
            m_wraps     <= 0;
            acc_data    <= 0;
            acc_done    <= 0;
            busy_cnt    <= 0;
        end else if (start && !run_busy) begin
            m_offset    <= '0;
            m_count     <= '0;
            m_done_next <= 1'b0;
            m_wraps     <= 0;
            acc_data    <= 0;
            acc_done    <= 0;
            busy_cnt    <= 0;
        end else begin
            if (run_busy) begin
                busy_cnt <= busy_cnt + 1;
            end
            if (accepted) begin
                if (acc_data == 0 && acc_done == 0) begin
                    first_dst <= wrdm_desc_dst_addr;
                end
                if (m_done_next) begin
                    m_done_next <= 1'b0;
                    acc_done    <= acc_done + 1;
                end else begin
                    acc_data    <= acc_data + 1;
                    m_count     <= m_count + 1;
                    m_offset    <= next_page(m_offset);
                    m_done_next <= write_pointer;
                    // a later data descriptor back at the ring start
                    if (acc_data != 0 && wrdm_desc_dst_addr == kmem_addr + 64) begin
                        m_wraps <= m_wraps + 1;
                    end
                end
            end
        end
    end

    // a done descriptor uses the offset that its data descriptor already advanced
    always_comb begin
        if (m_done_next) begin
            exp_dst  = kmem_addr + m_offset;
            exp_src  = {32'h0, m_count};
            exp_attr = {18'd1, 1'b1, 8'hfe};
        end else begin
            exp_dst  = kmem_addr + 64 + m_offset;
            exp_src  = 64'h0000_0000_0004_0000;
            exp_attr = {req_size[17:0], 1'b0, 8'h00};
        end
    end

    // ready is picked at the edge and applied just after it
    always @(posedge clk) begin
        mode_now = ready_mode;
        #1;
        case (mode_now)
            ready_high:   wrdm_desc_ready = 1'b1;
            ready_random: wrdm_desc_ready = ($random(seed) & 3) != 0;
            default:      wrdm_desc_ready = 1'b0;
        endcase
    end

    task automatic report_mismatch(input string what, input logic [512:0] expected,
                                   input logic [512:0] actual);
        errors++;
        $display("error %s %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    a_dst: assert property (@(posedge clk) disable iff (rst)
        accepted |-> wrdm_desc_dst_addr == exp_dst)
        else report_mismatch("dst_addr", $sampled(exp_dst), $sampled(wrdm_desc_dst_addr));

    a_src: assert property (@(posedge clk) disable iff (rst)
        accepted |-> wrdm_desc_src_data == exp_src)
        else report_mismatch("src_data", $sampled(exp_src), $sampled(wrdm_desc_src_data));

    // nb_dwords, immediate and tag checked together
    a_attr: assert property (@(posedge clk) disable iff (rst)
        accepted |-> {wrdm_desc_nb_dwords, wrdm_desc_immediate, wrdm_desc_id} == exp_attr)
        else report_mismatch("nb_dwords/immediate/id", $sampled(exp_attr),
                             $sampled({wrdm_desc_nb_dwords, wrdm_desc_immediate, wrdm_desc_id}));

    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        wrdm_desc_valid |-> wrdm_desc_ready && $past(wrdm_desc_ready, 1)
                            && $past(wrdm_desc_ready, 2))
        else report_failure("descriptor offered without three cycles of ready");

    a_only_busy: assert property (@(posedge clk) disable iff (rst)
        wrdm_desc_valid |-> run_busy)
        else report_failure("descriptor offered outside a run");

    a_busy_rise: assert property (@(posedge clk) disable iff (rst)
        start && !run_busy |=> run_busy)
        else report_failure("run_busy did not rise the cycle after start");

    a_tx_restart: assert property (@(posedge clk) disable iff (rst)
        $rose(run_busy) |=> transmit_cycles == 1)
        else report_mismatch("transmit_cycles", 1, $sampled(transmit_cycles));

    a_bram_read: assert property (@(posedge clk) disable iff (rst)
        frb_read && use_bram |=> ##1 (frb_readvalid && frb_readdata == exp_line))
        else report_mismatch("bram read", {1'b1, $sampled(exp_line)},
                             $sampled({frb_readvalid, frb_readdata}));

    a_fixed_read: assert property (@(posedge clk) disable iff (rst)
        frb_read && !use_bram |=> frb_readvalid && frb_readdata == exp_line)
        else report_mismatch("fixed read", {1'b1, $sampled(exp_line)},
                             $sampled({frb_readvalid, frb_readdata}));

    task automatic check_equal(input string what, input longint expected,
                               input longint actual);
        assert (expected == actual)
            else report_mismatch(what, expected, actual);
    endtask

    task automatic finish_run();
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("timeout: reset was never released");
            finish_run();
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (run_busy && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (run_busy) begin
            timeouts++;
            $display("timeout: %s still busy after %0d cycles", test_name, limit);
            finish_run();
        end
    endtask

    task automatic run_phase(input string name, input logic ptr, input int target,
                             input ready_mode_t mode);
        test_name          = name;
        write_pointer      = ptr;
        target_nb_requests = target;
        ready_mode         = mode;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_idle(target * 60);
        check_equal("data descriptors", target, acc_data);
        check_equal("done descriptors", ptr ? target : 0, acc_done);
    endtask

    // one read, then idle long enough for the slower path to finish
    task automatic read_line(input logic [5:0] addr, input logic bram);
        use_bram    = bram;
        exp_line    = bram ? babe_line(addr) : fixed_line();
        frb_address = addr;
        frb_read    = 1'b1;
        @(posedge clk);
        #1;
        frb_read = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    initial begin
        start              = 1'b0;
        write_pointer      = 1'b0;
        use_bram           = 1'b1;
        target_nb_requests = '0;
        req_size           = 32'd16;
        // 192 lines is a 12 KiB ring, so the fourth request wraps
        rb_size            = 31'd192;
        kmem_addr          = 64'h0000_0001_2340_0000;
        wrdm_desc_ready    = 1'b0;
        frb_read           = 1'b0;
        frb_address        = '0;
        exp_line           = '0;
        errors             = 0;
        timeouts           = 0;
        ready_mode         = ready_low;
        test_name          = "reset";

        wait_reset_release();
        ready_mode = ready_high;
        repeat (4) @(posedge clk);
        #1;

        run_phase("plain_run", 1'b0, 5, ready_high);
        assert (m_wraps > 0)
            else report_failure("the page offset never wrapped");

        run_phase("pointer_run", 1'b1, 4, ready_high);

        run_phase("backpressure_run", 1'b1, 5, ready_random);
        assert (dma_queue_full_cnt > 0)
            else report_failure("dma_queue_full_cnt stayed at zero under back-pressure");
        ready_mode = ready_high;

        test_name = "payload_read";
        repeat (66) @(posedge clk);
        #1;
        read_line(6'd0, 1'b1);
        read_line(6'd63, 1'b1);
        read_line(6'($random(seed) & 63), 1'b1);
        read_line(6'd5, 1'b0);
        read_line(6'd40, 1'b0);
        use_bram = 1'b1;

        run_phase("restart_run", 1'b0, 3, ready_high);
        check_equal("first dst_addr", kmem_addr + 64, first_dst);
        check_equal("transmit_cycles", busy_cnt, transmit_cycles);
        assert (transmit_cycles != 0)
            else report_failure("transmit_cycles is zero after a run");

        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
logic/pcie_prof_pkg.sv
logic/desc_if.sv
logic/data_desc_gen.sv
logic/done_desc_gen.sv
logic/desc_issuer.sv
logic/payload_buffer.sv
logic/pcie_tx_profiler.sv
dv/clk_gen.sv
dv/tb_pcie_tx_profiler.sv
